// File: verilog.f
+incdir+.
csr_pkg.sv
perf_cnt_if.sv
csr_access_decode.sv
machine_csr_regs.sv
perf_event_ctrl.sv
perf_counter.sv
csr_read_mux.sv
csr_top.sv
tb_csr_top.sv

// File: tb_csr_top.sv
// directed testbench for the csr block covering access ops, traps and counters
`timescale 1ns/1ps
`include "csr_cfg.svh"

module tb_csr_top;

  import csr_pkg::*;

  // limit well above the roughly 250 cycles the tests take
  localparam int MAX_CYCLES = 2000;

  logic                   clk;
  logic                   rst_n;
  logic                   csr_access;
  logic [`CSR_ADDR_W-1:0] csr_addr;
  logic [`CSR_XLEN-1:0]   csr_wdata;
  csr_op_e                csr_op;
  logic [`CSR_XLEN-1:0]   csr_rdata;
  logic                   save_cause, restore_mret;
  mcause_t                cause;
  logic [`CSR_XLEN-1:0]   pc_id;
  logic                   m_irq_enable;
  logic [`CSR_XLEN-1:0]   mepc;
  logic                   if_valid, id_valid, is_decoding, is_compressed;
  logic                   imiss, pc_set, mem_load, mem_store, jump, branch, branch_taken;

  logic [31:0]            rng_state = 32'h82afbf05;  // xorshift state
  int                     cycle_cnt = 0;

  csr_top csr_top_inst (
    .clk (clk), .rst_n (rst_n),
    .csr_access_i (csr_access), .csr_addr_i (csr_addr), .csr_wdata_i (csr_wdata),
    .csr_op_i (csr_op), .csr_rdata_o (csr_rdata),
    .csr_save_cause_i (save_cause), .csr_restore_mret_i (restore_mret),
    .csr_cause_i (cause), .pc_id_i (pc_id),
    .m_irq_enable_o (m_irq_enable), .mepc_o (mepc),
    .if_valid_i (if_valid), .id_valid_i (id_valid), .is_decoding_i (is_decoding),
    .is_compressed_i (is_compressed), .imiss_i (imiss), .pc_set_i (pc_set),
    .mem_load_i (mem_load), .mem_store_i (mem_store), .jump_i (jump),
    .branch_i (branch), .branch_taken_i (branch_taken)
  );

  always #10 clk = ~clk;  // 20 ns period

  // hang guard
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("TEST FAILED");
      $fatal(1, "timeout, run did not finish within %0d cycles", MAX_CYCLES);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
    if (actual !== expected) begin
      $display("mismatch at time %0t: %s, got %h expected %h", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "stopping on first error");
    end
  endtask

  task automatic reset_dut();
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  endtask

  // one access cycle with the write landing on the rising edge in between
  task automatic write_csr(input logic [11:0] addr, input logic [31:0] data, input csr_op_e op);
    @(negedge clk);
    csr_access = 1'b1;
    csr_addr   = addr;
    csr_wdata  = data;
    csr_op     = op;
    @(negedge clk);
    csr_access = 1'b0;
    csr_op     = CSR_OP_NONE;
  endtask

  // rdata is combinational so it is sampled mid low phase
  task automatic read_csr(input logic [11:0] addr, output logic [31:0] data);
    @(negedge clk);
    csr_access = 1'b1;
    csr_addr   = addr;
    csr_op     = CSR_OP_NONE;
    #5;
    data = csr_rdata;
    @(negedge clk);
    csr_access = 1'b0;
  endtask

  task automatic read_expect(input logic [11:0] addr, input logic [31:0] expected,
                             input string what);
    logic [31:0] data;
    read_csr(addr, data);
    compare_value(data, expected, what);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_values();
    read_expect(`CSR_ADDR_MSTATUS, 32'h0000_1800, "mstatus after reset");  // mpp = M
    read_expect(`CSR_ADDR_MEPC, 32'h0, "mepc after reset");
    read_expect(`CSR_ADDR_MCAUSE, 32'h0, "mcause after reset");
    read_expect(`CSR_ADDR_PCER, 32'h0, "pcer after reset");
    read_expect(`CSR_ADDR_PCMR, 32'h3, "pcmr after reset");
    for (int i = 0; i < `CSR_N_PERF; i++) begin
      read_expect({`CSR_PCCR_GROUP, 5'(i)}, 32'h0, $sformatf("pccr%0d after reset", i));
    end
    compare_value(m_irq_enable, 1'b0, "m_irq_enable after reset");
  endtask

  task automatic csr_ops();
    logic [31:0] model;
    logic [31:0] w;
    csr_op_e     op;
    model = 32'h0;
    for (int i = 0; i < 12; i++) begin
      w  = next_rand();
      op = csr_op_e'(next_rand() & 32'h3);
      write_csr(`CSR_ADDR_MEPC, w, op);
      case (op)
        CSR_OP_WRITE: model = w;
        CSR_OP_SET:   model = model | w;
        CSR_OP_CLEAR: model = model & ~w;
        default:      model = model;  // read only
      endcase
      read_expect(`CSR_ADDR_MEPC, model, $sformatf("mepc after op %s", op.name()));
      compare_value(mepc, model, "mepc_o");
    end
    // only mie and mpie stick
    for (int i = 0; i < 4; i++) begin
      w = next_rand();
      write_csr(`CSR_ADDR_MSTATUS, w, CSR_OP_WRITE);
      read_expect(`CSR_ADDR_MSTATUS, 32'h1800 | (w & 32'h88), "mstatus masked write");
      compare_value(m_irq_enable, w[3], "m_irq_enable follows mie");
    end
    // no write without access
    @(negedge clk);
    csr_addr  = `CSR_ADDR_MEPC;
    csr_wdata = ~model;
    csr_op    = CSR_OP_WRITE;
    @(negedge clk);
    csr_op    = CSR_OP_NONE;
    read_expect(`CSR_ADDR_MEPC, model, "mepc after write without access");
  endtask

  task automatic trap_return();
    logic [31:0] pc;
    pc = next_rand();
    write_csr(`CSR_ADDR_MSTATUS, 32'h8, CSR_OP_WRITE);  // mie on and mpie off
    @(negedge clk);
    pc_id      = pc;
    cause.irq  = 1'b1;
    cause.code = 5'd11;
    save_cause = 1'b1;
    @(negedge clk);
    save_cause = 1'b0;
    compare_value(mepc, pc, "mepc_o after trap");
    read_expect(`CSR_ADDR_MCAUSE, 32'h8000_000B, "mcause after trap");
    read_expect(`CSR_ADDR_MSTATUS, 32'h1880, "mstatus after trap");  // mpie set and mie clear
    compare_value(m_irq_enable, 1'b0, "m_irq_enable in handler");
    @(negedge clk);
    restore_mret = 1'b1;
    @(negedge clk);
    restore_mret = 1'b0;
    read_expect(`CSR_ADDR_MSTATUS, 32'h1888, "mstatus after mret");
    compare_value(m_irq_enable, 1'b1, "m_irq_enable after mret");
  endtask

  task automatic event_counting();
    int          n_load;
    int          n_branch;
    logic [31:0] r;
    n_load   = 0;
    n_branch = 0;
    write_csr(`CSR_ADDR_PCER, 32'h48, CSR_OP_WRITE);  // loads (3) and branches (6)
    for (int i = 0; i < 40; i++) begin
      @(negedge clk);
      r        = next_rand();
      mem_load = r[0];
      branch   = r[5];
      n_load   += r[0];
      n_branch += r[5];
    end
    @(negedge clk);
    mem_load = 1'b0;
    branch   = 1'b0;
    repeat (2) @(negedge clk);  // drain the inc stage
    read_expect({`CSR_PCCR_GROUP, 5'd3}, n_load, "load count");
    read_expect({`CSR_PCCR_GROUP, 5'd6}, n_branch, "branch count");
    read_expect({`CSR_PCCR_GROUP, 5'd0}, 32'h0, "cycle counter disabled");
    // global enable off with saturation kept
    write_csr(`CSR_ADDR_PCMR, 32'h2, CSR_OP_WRITE);
    repeat (10) begin
      @(negedge clk);
      mem_load = 1'b1;
      branch   = 1'b1;
    end
    @(negedge clk);
    mem_load = 1'b0;
    branch   = 1'b0;
    repeat (2) @(negedge clk);
    read_expect({`CSR_PCCR_GROUP, 5'd3}, n_load, "load count frozen");
    read_expect({`CSR_PCCR_GROUP, 5'd6}, n_branch, "branch count frozen");
    write_csr(`CSR_ADDR_PCMR, 32'h3, CSR_OP_WRITE);
  endtask

  task automatic counter_access();
    logic [31:0] exp_val;
    logic [31:0] w;
    w       = next_rand();
    exp_val = w;
    write_csr({`CSR_PCCR_GROUP, 5'd4}, w, CSR_OP_WRITE);
    read_expect({`CSR_PCCR_GROUP, 5'd4}, exp_val, "pccr4 write");
    w       = next_rand();
    exp_val = exp_val | w;
    write_csr({`CSR_PCCR_GROUP, 5'd4}, w, CSR_OP_SET);
    read_expect({`CSR_PCCR_GROUP, 5'd4}, exp_val, "pccr4 set");
    w       = next_rand();
    exp_val = exp_val & ~w;
    write_csr({`CSR_PCCR_GROUP, 5'd4}, w, CSR_OP_CLEAR);
    read_expect({`CSR_PCCR_GROUP, 5'd4}, exp_val, "pccr4 clear");
    // cycle counter near the top with saturation on
    write_csr(`CSR_ADDR_PCER, 32'h49, CSR_OP_WRITE);
    read_expect(`CSR_ADDR_PCER, 32'h49, "pcer readback");
    write_csr({`CSR_PCCR_GROUP, 5'd0}, 32'hFFFF_FFFD, CSR_OP_WRITE);
    repeat (10) @(negedge clk);
    read_expect({`CSR_PCCR_GROUP, 5'd0}, 32'hFFFF_FFFF, "cycle counter saturated");
    // slot 20 is empty
    write_csr({`CSR_PCCR_GROUP, 5'd20}, next_rand(), CSR_OP_WRITE);
    read_expect({`CSR_PCCR_GROUP, 5'd20}, 32'h0, "pccr20 reads zero");
    read_expect({`CSR_PCCR_GROUP, 5'd4}, exp_val, "pccr4 untouched by pccr20 write");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    csr_access    = 1'b0;
    csr_addr      = '0;
    csr_wdata     = '0;
    csr_op        = CSR_OP_NONE;
    save_cause    = 1'b0;
    restore_mret  = 1'b0;
    cause         = '0;
    pc_id         = '0;
    if_valid      = 1'b0;
    id_valid      = 1'b0;
    is_decoding   = 1'b0;
    is_compressed = 1'b0;
    imiss         = 1'b0;
    pc_set        = 1'b0;
    mem_load      = 1'b0;
    mem_store     = 1'b0;
    jump          = 1'b0;
    branch        = 1'b0;
    branch_taken  = 1'b0;

    reset_dut();
    reset_values();
    csr_ops();
    trap_return();
    event_counting();
    counter_access();

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: csr_top.sv
// machine-mode csr block with nine performance counters, single-cycle access port
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // access port, sram-like
  input  logic                   csr_access_i,
  input  logic [`CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [`CSR_XLEN-1:0]   csr_wdata_i,
  input  csr_pkg::csr_op_e       csr_op_i,
  output logic [`CSR_XLEN-1:0]   csr_rdata_o,
  // trap control
  input  logic                   csr_save_cause_i,
  input  logic                   csr_restore_mret_i,
  input  csr_pkg::mcause_t       csr_cause_i,
  input  logic [`CSR_XLEN-1:0]   pc_id_i,
  output logic                   m_irq_enable_o,
  output logic [`CSR_XLEN-1:0]   mepc_o,
  // pipeline events
  input  logic                   if_valid_i,
  input  logic                   id_valid_i,
  input  logic                   is_decoding_i,
  input  logic                   is_compressed_i,
  input  logic                   imiss_i,
  input  logic                   pc_set_i,
  input  logic                   mem_load_i,
  input  logic                   mem_store_i,
  input  logic                   jump_i,
  input  logic                   branch_i,
  input  logic                   branch_taken_i
);

  import csr_pkg::*;

  logic [`CSR_XLEN-1:0]   wdata;        // merged write data
  logic                   mstatus_we, mepc_we, mcause_we;
  logic                   pcer_we, pcmr_we;
  csr_rd_sel_e            rd_sel;
  logic [4:0]             pccr_index;
  mstatus_t               mstatus;
  mcause_t                mcause;
  logic [`CSR_N_PERF-1:0] pcer;
  logic [1:0]             pcmr;

  perf_cnt_if cnt_bus [`CSR_N_PERF] ();  // one bus per counter

  csr_access_decode u_decode (
    .csr_access_i (csr_access_i), .csr_addr_i (csr_addr_i),
    .csr_op_i     (csr_op_i),     .csr_wdata_i (csr_wdata_i),
    .csr_rdata_i  (csr_rdata_o),  .wdata_o     (wdata),
    .mstatus_we_o (mstatus_we),   .mepc_we_o   (mepc_we),
    .mcause_we_o  (mcause_we),    .pcer_we_o   (pcer_we),
    .pcmr_we_o    (pcmr_we),      .rd_sel_o    (rd_sel),
    .pccr_index_o (pccr_index),   .cnt_bus     (cnt_bus)
  );

  machine_csr_regs u_mregs (
    .clk (clk), .rst_n (rst_n), .wdata_i (wdata),
    .mstatus_we_i (mstatus_we), .mepc_we_i (mepc_we), .mcause_we_i (mcause_we),
    .csr_save_cause_i (csr_save_cause_i), .csr_restore_mret_i (csr_restore_mret_i),
    .csr_cause_i (csr_cause_i), .pc_id_i (pc_id_i),
    .mstatus_o (mstatus), .mepc_o (mepc_o), .mcause_o (mcause)
  );

  perf_event_ctrl u_events (
    .clk (clk), .rst_n (rst_n), .wdata_i (wdata),
    .pcer_we_i (pcer_we), .pcmr_we_i (pcmr_we),
    .if_valid_i (if_valid_i), .id_valid_i (id_valid_i), .is_decoding_i (is_decoding_i),
    .is_compressed_i (is_compressed_i), .imiss_i (imiss_i), .pc_set_i (pc_set_i),
    .mem_load_i (mem_load_i), .mem_store_i (mem_store_i), .jump_i (jump_i),
    .branch_i (branch_i), .branch_taken_i (branch_taken_i),
    .pcer_o (pcer), .pcmr_o (pcmr), .cnt_bus (cnt_bus)
  );

  for (genvar i = 0; i < `CSR_N_PERF; i++) begin : gen_cnt
    perf_counter u_cnt (.clk (clk), .rst_n (rst_n), .cnt_bus (cnt_bus[i]));
  end

  csr_read_mux u_rmux (
    .rd_sel_i (rd_sel), .pccr_index_i (pccr_index), .mstatus_i (mstatus),
    .mepc_i (mepc_o), .mcause_i (mcause), .pcer_i (pcer), .pcmr_i (pcmr),
    .csr_rdata_o (csr_rdata_o), .cnt_bus (cnt_bus)
  );

  assign m_irq_enable_o = mstatus.mie;  // global interrupt enable to the controller

endmodule

// File: csr_read_mux.sv
// csr read data mux: formats machine csrs and picks pcer, pcmr or a counter
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_read_mux (
  input  csr_pkg::csr_rd_sel_e    rd_sel_i,
  input  logic [4:0]              pccr_index_i,
  input  csr_pkg::mstatus_t       mstatus_i,
  input  logic [`CSR_XLEN-1:0]    mepc_i,
  input  csr_pkg::mcause_t        mcause_i,
  input  logic [`CSR_N_PERF-1:0]  pcer_i,
  input  logic [1:0]              pcmr_i,
  output logic [`CSR_XLEN-1:0]    csr_rdata_o,
  perf_cnt_if.reader              cnt_bus [`CSR_N_PERF]
);

  import csr_pkg::*;

  logic [`CSR_N_PERF-1:0][`CSR_XLEN-1:0] cnt_words;  // flattened counter values
  logic [`CSR_XLEN-1:0]                  mstatus_word;
  logic [`CSR_XLEN-1:0]                  pccr_word;

  // interface arrays only take constant indices
  for (genvar i = 0; i < `CSR_N_PERF; i++) begin : gen_cnt_rd
    assign cnt_words[i] = cnt_bus[i].count;
  end

  always_comb begin : mstatus_fmt
    mstatus_word                        = '0;
    mstatus_word[12:11]                 = 2'b11;  // mpp, M only
    mstatus_word[`CSR_MSTATUS_MPIE_BIT] = mstatus_i.mpie;
    mstatus_word[`CSR_MSTATUS_MIE_BIT]  = mstatus_i.mie;
  end

  // unimplemented slots 9..31 read zero
  assign pccr_word = (pccr_index_i < `CSR_N_PERF) ? cnt_words[pccr_index_i] : '0;

  ////////////////////////////////////////////////////////////////////////////
  // output select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : rdata_sel
    case (rd_sel_i)
      RD_MSTATUS: csr_rdata_o = mstatus_word;
      RD_MEPC:    csr_rdata_o = mepc_i;
      RD_MCAUSE:  csr_rdata_o = {mcause_i.irq, {(`CSR_XLEN-6){1'b0}}, mcause_i.code};
      RD_PCER:    csr_rdata_o = {{(`CSR_XLEN-`CSR_N_PERF){1'b0}}, pcer_i};
      RD_PCMR:    csr_rdata_o = {{(`CSR_XLEN-2){1'b0}}, pcmr_i};
      RD_PCCR:    csr_rdata_o = pccr_word;
      default:    csr_rdata_o = '0;  // idle or unmapped
    endcase
  end

endmodule

// File: perf_counter.sv
// single 32-bit event counter, wrapping or saturating, loadable by software
`timescale 1ns/1ps
`include "csr_cfg.svh"

module perf_counter (
  input  logic         clk,
  input  logic         rst_n,
  perf_cnt_if.counter  cnt_bus
);

  logic [`CSR_XLEN-1:0] count_q;
  logic                 at_max;    // all ones
  logic                 step;      // increment allowed this cycle

  assign at_max = &count_q;

  // saturation only blocks the step at the top, wrap otherwise
  assign step = cnt_bus.inc && !(cnt_bus.sat && at_max);

  ////////////////////////////////////////////////////////////////////////////
  // count register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (cnt_bus.we) begin
      count_q <= cnt_bus.wdata;          // software load beats the event
    end else if (step) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign cnt_bus.count = count_q;

endmodule

// File: perf_event_ctrl.sv
// perf counter control: pcer/pcmr registers, event gating and increment pipeline
`timescale 1ns/1ps
`include "csr_cfg.svh"

module perf_event_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`CSR_XLEN-1:0]   wdata_i,
  input  logic                   pcer_we_i,
  input  logic                   pcmr_we_i,
  input  logic                   if_valid_i,      // new instr out of IF
  input  logic                   id_valid_i,      // ID done
  input  logic                   is_decoding_i,   // controller in decode
  input  logic                   is_compressed_i, // rvc in ID
  input  logic                   imiss_i,         // fetch stall
  input  logic                   pc_set_i,        // redirect in flight
  input  logic                   mem_load_i,
  input  logic                   mem_store_i,
  input  logic                   jump_i,
  input  logic                   branch_i,
  input  logic                   branch_taken_i,
  output logic [`CSR_N_PERF-1:0] pcer_o,
  output logic [1:0]             pcmr_o,
  perf_cnt_if.feeder             cnt_bus [`CSR_N_PERF]
);

  logic [`CSR_N_PERF-1:0] pcer_q;
  logic [1:0]             pcmr_q;      // [0] global enable, [1] saturate
  logic [`CSR_N_PERF-1:0] event_raw;
  logic [`CSR_N_PERF-1:0] inc_d, inc_q;

  ////////////////////////////////////////////////////////////////////////////
  // event map, index = pccr number
  ////////////////////////////////////////////////////////////////////////////

  assign event_raw[0] = 1'b1;                  // cycles
  assign event_raw[1] = if_valid_i;            // fetched instrs
  assign event_raw[2] = imiss_i & ~pc_set_i;   // fetch-miss cycles, not redirects
  assign event_raw[3] = mem_load_i;
  assign event_raw[4] = mem_store_i;
  assign event_raw[5] = jump_i;
  assign event_raw[6] = branch_i;
  assign event_raw[7] = branch_taken_i;
  assign event_raw[8] = id_valid_i & is_decoding_i & is_compressed_i;  // compressed

  // per-counter enable and global enable
  assign inc_d = event_raw & pcer_q & {`CSR_N_PERF{pcmr_q[0]}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcer_q <= '0;
      pcmr_q <= `CSR_PCMR_RST;
      inc_q  <= '0;
    end else begin
      if (pcer_we_i) begin
        pcer_q <= wdata_i[`CSR_N_PERF-1:0];
      end
      if (pcmr_we_i) begin
        pcmr_q <= wdata_i[1:0];
      end
      inc_q <= inc_d;  // one stage, count moves a cycle later
    end
  end

  for (genvar i = 0; i < `CSR_N_PERF; i++) begin : gen_feed
    assign cnt_bus[i].inc = inc_q[i];
    assign cnt_bus[i].sat = pcmr_q[1];
  end

  assign pcer_o = pcer_q;
  assign pcmr_o = pcmr_q;

endmodule

// File: machine_csr_regs.sv
// machine status, exception pc and cause registers with trap entry and mret
`timescale 1ns/1ps
`include "csr_cfg.svh"

module machine_csr_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`CSR_XLEN-1:0]  wdata_i,            // merged write data
  input  logic                  mstatus_we_i,
  input  logic                  mepc_we_i,
  input  logic                  mcause_we_i,
  input  logic                  csr_save_cause_i,   // trap entry
  input  logic                  csr_restore_mret_i, // return from trap
  input  csr_pkg::mcause_t      csr_cause_i,
  input  logic [`CSR_XLEN-1:0]  pc_id_i,            // pc of the trapping instr
  output csr_pkg::mstatus_t     mstatus_o,
  output logic [`CSR_XLEN-1:0]  mepc_o,
  output csr_pkg::mcause_t      mcause_o
);

  import csr_pkg::*;

  mstatus_t             mstatus_q, mstatus_d;
  logic [`CSR_XLEN-1:0] mepc_q, mepc_d;
  mcause_t              mcause_q, mcause_d;

  ////////////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : next_state
    mstatus_d = mstatus_q;
    mepc_d    = mepc_q;
    mcause_d  = mcause_q;

    // software writes first
    if (mstatus_we_i) begin
      mstatus_d.mie  = wdata_i[`CSR_MSTATUS_MIE_BIT];   // only two live bits
      mstatus_d.mpie = wdata_i[`CSR_MSTATUS_MPIE_BIT];
    end
    if (mepc_we_i) begin
      mepc_d = wdata_i;
    end
    if (mcause_we_i) begin
      mcause_d.irq  = wdata_i[`CSR_XLEN-1];
      mcause_d.code = wdata_i[4:0];
    end

    // the controller wins over any software write in the same cycle
    if (csr_save_cause_i) begin
      mstatus_d.mpie = mstatus_q.mie;  // stack the enable
      mstatus_d.mie  = 1'b0;           // mask while in handler
      mepc_d         = pc_id_i;
      mcause_d       = csr_cause_i;
    end else if (csr_restore_mret_i) begin
      mstatus_d.mie  = mstatus_q.mpie; // pop
      mstatus_d.mpie = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q <= '0;  // interrupts off
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      mstatus_q <= mstatus_d;
      mepc_q    <= mepc_d;
      mcause_q  <= mcause_d;
    end
  end

  assign mstatus_o = mstatus_q;
  assign mepc_o    = mepc_q;
  assign mcause_o  = mcause_q;

endmodule

// File: csr_access_decode.sv
// csr access decoder: address to read select, write strobes and set/clear merge
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_access_decode (
  input  logic                    csr_access_i,
  input  logic [`CSR_ADDR_W-1:0]  csr_addr_i,
  input  csr_pkg::csr_op_e        csr_op_i,
  input  logic [`CSR_XLEN-1:0]    csr_wdata_i,
  input  logic [`CSR_XLEN-1:0]    csr_rdata_i,    // current value, for set/clear
  output logic [`CSR_XLEN-1:0]    wdata_o,
  output logic                    mstatus_we_o,
  output logic                    mepc_we_o,
  output logic                    mcause_we_o,
  output logic                    pcer_we_o,
  output logic                    pcmr_we_o,
  output csr_pkg::csr_rd_sel_e    rd_sel_o,
  output logic [4:0]              pccr_index_o,
  perf_cnt_if.decoder             cnt_bus [`CSR_N_PERF]
);

  import csr_pkg::*;

  csr_addr_u addr;
  logic      wr_en;    // any modifying op on a live access
  logic      is_pccr;  // address inside the counter group

  assign addr         = csr_addr_i;
  assign wr_en        = csr_access_i && (csr_op_i != CSR_OP_NONE);
  assign is_pccr      = csr_access_i && (addr.pccr.group == `CSR_PCCR_GROUP);
  assign pccr_index_o = addr.pccr.idx;

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  // depends on address only, never on read data, so no loop through the mux
  always_comb begin : sel_decode
    rd_sel_o = RD_NONE;  // idle or unmapped
    if (is_pccr) begin
      rd_sel_o = RD_PCCR;
    end else if (csr_access_i) begin
      case (addr.raw)
        `CSR_ADDR_MSTATUS: rd_sel_o = RD_MSTATUS;
        `CSR_ADDR_MEPC:    rd_sel_o = RD_MEPC;
        `CSR_ADDR_MCAUSE:  rd_sel_o = RD_MCAUSE;
        `CSR_ADDR_PCER:    rd_sel_o = RD_PCER;
        `CSR_ADDR_PCMR:    rd_sel_o = RD_PCMR;
        default:           rd_sel_o = RD_NONE;
      endcase
    end
  end

  // one strobe per target, rd_sel is already one-hot by construction
  assign mstatus_we_o = wr_en && (rd_sel_o == RD_MSTATUS);
  assign mepc_we_o    = wr_en && (rd_sel_o == RD_MEPC);
  assign mcause_we_o  = wr_en && (rd_sel_o == RD_MCAUSE);
  assign pcer_we_o    = wr_en && (rd_sel_o == RD_PCER);
  assign pcmr_we_o    = wr_en && (rd_sel_o == RD_PCMR);

  ////////////////////////////////////////////////////////////////////////////
  // write data merge
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : wdata_merge
    case (csr_op_i)
      CSR_OP_SET:   wdata_o = csr_wdata_i | csr_rdata_i;
      CSR_OP_CLEAR: wdata_o = ~csr_wdata_i & csr_rdata_i;
      default:      wdata_o = csr_wdata_i;  // write, none
    endcase
  end

  // counter load strobes, index 9..31 hits nothing
  for (genvar i = 0; i < `CSR_N_PERF; i++) begin : gen_cnt_we
    assign cnt_bus[i].we    = wr_en && is_pccr && (addr.pccr.idx == i);
    assign cnt_bus[i].wdata = wdata_o;
  end

endmodule

// File: perf_cnt_if.sv
// per-counter bus carrying increment, mode, software load and count value
`timescale 1ns/1ps
`include "csr_cfg.svh"

interface perf_cnt_if;

  logic                 inc;    // registered, gated event
  logic                 sat;    // hold at all ones
  logic                 we;     // software load strobe
  logic [`CSR_XLEN-1:0] wdata;  // merged write data
  logic [`CSR_XLEN-1:0] count;  // current value

  // event side, pcer/pcmr owner
  modport feeder (
    output inc,
    output sat
  );

  // csr access side
  modport decoder (
    output we,
    output wdata
  );

  modport counter (
    input  inc,
    input  sat,
    input  we,
    input  wdata,
    output count
  );

  // read path only
  modport reader (
    input count
  );

endinterface

// File: csr_pkg.sv
// csr types shared by the decoder, machine registers, read mux and top level
package csr_pkg;

  `include "csr_cfg.svh"

  ////////////////////////////////////////////////////////////////////////////
  // access port
  ////////////////////////////////////////////////////////////////////////////

  // operation on the access port, encoding follows the core's decoder
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,  // read only
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,  // or into current value
    CSR_OP_CLEAR = 2'b11   // and with inverted wdata
  } csr_op_e;

  // read source picked by the address decoder
  typedef enum logic [2:0] {
    RD_NONE    = 3'd0,  // idle or unmapped, reads zero
    RD_MSTATUS = 3'd1,
    RD_MEPC    = 3'd2,
    RD_MCAUSE  = 3'd3,
    RD_PCER    = 3'd4,
    RD_PCMR    = 3'd5,
    RD_PCCR    = 3'd6   // counter group, index picks the word
  } csr_rd_sel_e;

  // address seen either as a plain csr number or as counter group plus index
  typedef union packed {
    logic [`CSR_ADDR_W-1:0] raw;
    struct packed {
      logic [6:0] group;  // 0x3C for 0x780..0x79F
      logic [4:0] idx;    // counter index
    } pccr;
  } csr_addr_u;

  ////////////////////////////////////////////////////////////////////////////
  // machine state
  ////////////////////////////////////////////////////////////////////////////

  // only the two enable bits are stored, mpp is always M
  typedef struct packed {
    logic mie;
    logic mpie;
  } mstatus_t;

  typedef struct packed {
    logic       irq;   // interrupt vs exception, bit 31 on read
    logic [4:0] code;
  } mcause_t;

endpackage

// File: csr_cfg.svh
// csr block configuration: word and address widths, counter count, csr map, reset values
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// widths
`define CSR_XLEN             32   // data word
`define CSR_ADDR_W           12   // csr address
`define CSR_N_PERF           9    // implemented event counters

// machine csr addresses
`define CSR_ADDR_MSTATUS     12'h300
`define CSR_ADDR_MEPC        12'h341
`define CSR_ADDR_MCAUSE      12'h342

// perf counter control
`define CSR_ADDR_PCER        12'h7A0  // per-counter enable
`define CSR_ADDR_PCMR        12'h7A1  // global enable and saturation
`define CSR_PCCR_GROUP       7'h3C    // upper addr bits of 0x780..0x79F

// reset values and field positions
`define CSR_PCMR_RST         2'd3     // counting on, saturation on
`define CSR_MSTATUS_MIE_BIT  3
`define CSR_MSTATUS_MPIE_BIT 7

`endif
